// ==== hdl/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    // conditional branch fields
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // for jal the rs1 and funct3 slots carry imm[19:12]
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        logic [31:0] raw;
        b_fmt_t      b;
        j_fmt_t      j;
    } instr_u;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic        pred_taken;
        logic [31:0] pred_next;
    } fetch_pkt_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        taken;
    } bht_update_t;

endpackage

`default_nettype wire

// ==== hdl/pc_gen.sv ====
`default_nettype none

module pc_gen #(
    parameter int CREDITS = 4
) (
    input  logic                clk,
    input  logic                rst_n_i,

    input  logic                pred_redirect_i,
    input  logic [31:0]         pred_target_i,
    input  fetch_pkg::redirect_t redirect_i,

    input  logic                credit_i,
    input  logic [1:0]          refund_i,

    output logic                req_o,
    output logic [31:0]         req_pc_o
);

    import fetch_pkg::*;

    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [31:0]    pc_q;
    logic [31:0]    pc_next;
    logic           req_q;
    logic           req_next;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W:0] avail;
    logic [CNT_W:0] cnt_next;

////////////////////////////////////////////////////////////
    // credits
////////////////////////////////////////////////////////////

    // count excludes the request currently on the bus
    assign avail = {1'b0, cnt_q}
                 + (CNT_W+1)'(credit_i)
                 + (CNT_W+1)'(refund_i);

    assign req_next = (avail != '0);
    assign cnt_next = avail - (CNT_W+1)'(req_next);

////////////////////////////////////////////////////////////
    // next pc
////////////////////////////////////////////////////////////

    always_comb begin
        if (redirect_i.valid) begin
            pc_next = redirect_i.pc;
        end else if (pred_redirect_i) begin
            pc_next = pred_target_i;
        end else if (req_q) begin
            pc_next = pc_q + 32'd4;
        end else begin
            // hold while out of credit
            pc_next = pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q  <= RESET_PC;
            req_q <= 1'b0;
            cnt_q <= CNT_W'(CREDITS);
        end else begin
            pc_q  <= pc_next;
            req_q <= req_next;
            cnt_q <= cnt_next[CNT_W-1:0];
        end
    end

    assign req_o    = req_q;
    assign req_pc_o = pc_q;

endmodule

`default_nettype wire

// ==== hdl/predecode.sv ====
`default_nettype none

module predecode (
    input  fetch_pkg::instr_u instr_i,

    output logic        is_branch_o,
    output logic        is_jal_o,
    output logic        is_jalr_o,
    output logic        is_link_o,
    output logic        is_return_o,
    output logic [31:0] imm_b_o,
    output logic [31:0] imm_j_o
);

    import fetch_pkg::*;

    logic [4:0] rd;
    logic [4:0] rs1;
    logic       rd_link;
    logic       rs1_link;

    // opcode classes
    assign is_branch_o = (instr_i.b.opcode == OPC_BRANCH);
    assign is_jal_o    = (instr_i.j.opcode == OPC_JAL);
    assign is_jalr_o   = (instr_i.j.opcode == OPC_JALR) && (instr_i.j.funct3 == 3'b000);

    // link registers are x1 and x5
    assign rd       = instr_i.j.rd;
    assign rs1      = instr_i.j.rs1;
    assign rd_link  = (rd == 5'd1) || (rd == 5'd5);
    assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

    assign is_link_o   = (is_jal_o || is_jalr_o) && rd_link;
    assign is_return_o = is_jalr_o && (rd == 5'd0) && rs1_link;

////////////////////////////////////////////////////////////
    // immediates
////////////////////////////////////////////////////////////

    assign imm_b_o = {{19{instr_i.b.imm12}},
                      instr_i.b.imm12,
                      instr_i.b.imm11,
                      instr_i.b.imm10_5,
                      instr_i.b.imm4_1,
                      1'b0};

    assign imm_j_o = {{11{instr_i.j.imm20}},
                      instr_i.j.imm20,
                      instr_i.j.rs1,
                      instr_i.j.funct3,
                      instr_i.j.imm11,
                      instr_i.j.imm10_1,
                      1'b0};

endmodule

`default_nettype wire

// ==== hdl/branch_predictor.sv ====
`default_nettype none

module branch_predictor #(
    parameter int BHT_IDX_BITS = 6
) (
    input  logic                    clk,
    input  logic                    rst_n_i,

    input  logic [31:0]             lookup_pc_i,
    output logic                    taken_o,

    input  fetch_pkg::bht_update_t  upd_i
);

    localparam int ENTRIES = 1 << BHT_IDX_BITS;

    logic [1:0]              ctr_q [ENTRIES];
    logic [BHT_IDX_BITS-1:0] look_idx;
    logic [BHT_IDX_BITS-1:0] upd_idx;
    logic [1:0]              upd_old;
    logic [1:0]              upd_new;

    // word aligned index
    assign look_idx = lookup_pc_i[BHT_IDX_BITS+1:2];
    assign upd_idx  = upd_i.pc[BHT_IDX_BITS+1:2];

    // msb of the counter is the prediction
    assign taken_o = ctr_q[look_idx][1];

    assign upd_old = ctr_q[upd_idx];

    // saturating step
    always_comb begin
        upd_new = upd_old;
        if (upd_i.taken && (upd_old != 2'b11)) begin
            upd_new = upd_old + 2'b01;
        end else if (!upd_i.taken && (upd_old != 2'b00)) begin
            upd_new = upd_old - 2'b01;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            // weakly not taken
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_q[i] <= 2'b01;
            end
        end else if (upd_i.valid) begin
            ctr_q[upd_idx] <= upd_new;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/return_stack.sv ====
`default_nettype none

module return_stack #(
    parameter int RAS_DEPTH = 4
) (
    input  logic        clk,
    input  logic        rst_n_i,

    input  logic        push_i,
    input  logic [31:0] push_addr_i,
    input  logic        pop_i,

    output logic [31:0] top_o,
    output logic        empty_o
);

    localparam int PTR_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
    localparam int CNT_W = $clog2(RAS_DEPTH + 1);

    logic [31:0]      stack_q [RAS_DEPTH];
    logic [PTR_W-1:0] sp_q;
    logic [PTR_W-1:0] sp_inc;
    logic [PTR_W-1:0] sp_dec;
    logic [CNT_W-1:0] cnt_q;
    logic             pop_ok;

    // wrap around the buffer
    assign sp_inc = (sp_q == PTR_W'(RAS_DEPTH - 1)) ? '0 : sp_q + 1'b1;
    assign sp_dec = (sp_q == '0) ? PTR_W'(RAS_DEPTH - 1) : sp_q - 1'b1;

    assign empty_o = (cnt_q == '0);
    assign pop_ok  = pop_i && !empty_o;
    assign top_o   = stack_q[sp_q];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sp_q  <= '0;
            cnt_q <= '0;
        end else if (push_i && pop_ok) begin
            stack_q[sp_q] <= push_addr_i;
        end else if (push_i) begin
            // overwrites the oldest entry when full
            stack_q[sp_inc] <= push_addr_i;
            sp_q            <= sp_inc;
            if (cnt_q != CNT_W'(RAS_DEPTH)) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end else if (pop_ok) begin
            sp_q  <= sp_dec;
            cnt_q <= cnt_q - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
`default_nettype none

module fetch_stage #(
    parameter int BHT_IDX_BITS = 6,
    parameter int RAS_DEPTH    = 4
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    req_i,
    input  logic [31:0]             req_pc_i,
    input  logic [31:0]             imem_rdata_i,
    input  fetch_pkg::redirect_t    redirect_i,
    input  fetch_pkg::bht_update_t  bht_upd_i,
    output logic                    pred_redirect_o,
    output logic [31:0]             pred_target_o,
    output logic [1:0]              refund_o,
    output logic                    pkt_valid_o,
    output fetch_pkg::fetch_pkt_t   pkt_o
);

    import fetch_pkg::*;

    logic        valid_q, live;
    logic [31:0] pc_q, seq_pc;
    instr_u      instr_w;
    logic        is_branch, is_jal, is_link, is_return;
    logic [31:0] imm_b, imm_j;
    logic        bht_taken, ras_empty, ras_push, ras_pop;
    logic [31:0] ras_top;
    logic        pred_taken;
    logic [31:0] pred_next;
    fetch_pkt_t  pkt_q;
    logic        pkt_valid_q;

    assign instr_w = imem_rdata_i;

    predecode predecode_inst (
        .instr_i(instr_w), .is_branch_o(is_branch), .is_jal_o(is_jal),
        .is_jalr_o(), .is_link_o(is_link), .is_return_o(is_return),
        .imm_b_o(imm_b), .imm_j_o(imm_j)
    );

    branch_predictor #(.BHT_IDX_BITS(BHT_IDX_BITS)) branch_predictor_inst (
        .clk(clk), .rst_n_i(rst_n_i), .lookup_pc_i(pc_q),
        .taken_o(bht_taken), .upd_i(bht_upd_i)
    );

    return_stack #(.RAS_DEPTH(RAS_DEPTH)) return_stack_inst (
        .clk(clk), .rst_n_i(rst_n_i), .push_i(ras_push), .push_addr_i(seq_pc),
        .pop_i(ras_pop), .top_o(ras_top), .empty_o(ras_empty)
    );

    always_comb begin
        seq_pc     = pc_q + 32'd4;
        pred_taken = 1'b0;
        pred_next  = seq_pc;
        if (is_jal) begin
            pred_taken = 1'b1;
            pred_next  = pc_q + imm_j;
        end else if (is_branch && bht_taken) begin
            pred_taken = 1'b1;
            pred_next  = pc_q + imm_b;
        end else if (is_return && !ras_empty) begin
            pred_taken = 1'b1;
            pred_next  = ras_top;
        end
    end

    // back-end redirect kills the word in this stage
    assign live            = valid_q && !redirect_i.valid;
    assign pred_redirect_o = live && pred_taken;
    assign pred_target_o   = pred_next;
    assign ras_push        = live && is_link;
    assign ras_pop         = live && is_return && !ras_empty;

    assign refund_o = {1'b0, valid_q && redirect_i.valid}
                    + {1'b0, req_i && (redirect_i.valid || pred_redirect_o)};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q     <= 1'b0;
            pkt_valid_q <= 1'b0;
        end else begin
            valid_q     <= req_i && !redirect_i.valid && !pred_redirect_o;
            pkt_valid_q <= live;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i) begin
            pc_q <= req_pc_i;
        end
        if (live) begin
            pkt_q <= '{pc: pc_q, instr: imem_rdata_i, pred_taken: pred_taken,
                       pred_next: pred_next};
        end
    end

    assign pkt_valid_o = pkt_valid_q;
    assign pkt_o       = pkt_q;

endmodule

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
`default_nettype none

module fetch_unit #(
    parameter int BHT_IDX_BITS = 6,
    parameter int RAS_DEPTH    = 4,
    parameter int CREDITS      = 4
) (
    input  logic                    clk,
    input  logic                    rst_n_i,

    // instruction memory
    output logic                    imem_req_o,
    output logic [31:0]             imem_addr_o,
    input  logic [31:0]             imem_rdata_i,

    // decode side
    output logic                    pkt_valid_o,
    output fetch_pkg::fetch_pkt_t   pkt_o,
    input  logic                    credit_i,

    // back end
    input  fetch_pkg::redirect_t    redirect_i,
    input  fetch_pkg::bht_update_t  bht_upd_i
);

    logic        pred_redirect;
    logic [31:0] pred_target;
    logic [1:0]  refund;

////////////////////////////////////////////////////////////
    // stage one
////////////////////////////////////////////////////////////

    pc_gen #(
        .CREDITS(CREDITS)
    ) pc_gen_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .pred_redirect_i(pred_redirect),
        .pred_target_i  (pred_target),
        .redirect_i     (redirect_i),
        .credit_i       (credit_i),
        .refund_i       (refund),
        .req_o          (imem_req_o),
        .req_pc_o       (imem_addr_o)
    );

////////////////////////////////////////////////////////////
    // stage two
////////////////////////////////////////////////////////////

    fetch_stage #(
        .BHT_IDX_BITS(BHT_IDX_BITS),
        .RAS_DEPTH   (RAS_DEPTH)
    ) fetch_stage_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .req_i          (imem_req_o),
        .req_pc_i       (imem_addr_o),
        .imem_rdata_i   (imem_rdata_i),
        .redirect_i     (redirect_i),
        .bht_upd_i      (bht_upd_i),
        .pred_redirect_o(pred_redirect),
        .pred_target_o  (pred_target),
        .refund_o       (refund),
        .pkt_valid_o    (pkt_valid_o),
        .pkt_o          (pkt_o)
    );

endmodule

`default_nettype wire

// ==== include/fetch_tb_util.svh ====
`ifndef FETCH_TB_UTIL_SVH
`define FETCH_TB_UTIL_SVH

logic [31:0] lfsr_q;
logic [1:0]  bht_m [1 << BHT_IDX_BITS];
logic [31:0] ras_m [$];
int          err_cnt;
int          chk_cnt;

////////////////////////////////////////////////////////////
// random numbers
////////////////////////////////////////////////////////////

// galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// one lfsr step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_q = lfsr_next(lfsr_q);
        r      = {r[30:0], lfsr_q[0]};
    end
    return r;
endfunction

////////////////////////////////////////////////////////////
// reference model
////////////////////////////////////////////////////////////

task automatic clear_model();
    for (int i = 0; i < (1 << BHT_IDX_BITS); i++) begin
        bht_m[i] = 2'd1;
    end
    ras_m.delete();
endtask

task automatic train_counters(input bht_update_t u);
    logic [BHT_IDX_BITS-1:0] idx;
    idx = u.pc[BHT_IDX_BITS+1:2];
    if (u.valid && u.taken && (bht_m[idx] != 2'd3)) begin
        bht_m[idx] = bht_m[idx] + 2'd1;
    end else if (u.valid && !u.taken && (bht_m[idx] != 2'd0)) begin
        bht_m[idx] = bht_m[idx] - 2'd1;
    end
endtask

// expected packet for a live word and its stack side effects
task automatic predict_packet(input logic [31:0] pc, input logic [31:0] word,
                              output fetch_pkt_t want);
    instr_u      w;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        jalr;
    logic        link;
    logic        ret;
    w.raw = word;
    imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
    imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    jalr  = (w.j.opcode == OPC_JALR) && (w.j.funct3 == 3'd0);
    link  = ((w.j.opcode == OPC_JAL) || jalr) && ((w.j.rd == 5'd1) || (w.j.rd == 5'd5));
    ret   = jalr && (w.j.rd == 5'd0) && ((w.j.rs1 == 5'd1) || (w.j.rs1 == 5'd5));
    want.pc         = pc;
    want.instr      = word;
    want.pred_taken = 1'b0;
    want.pred_next  = pc + 32'd4;
    if (w.j.opcode == OPC_JAL) begin
        want.pred_taken = 1'b1;
        want.pred_next  = pc + imm_j;
    end else if ((w.b.opcode == OPC_BRANCH) && (bht_m[pc[BHT_IDX_BITS+1:2]] >= 2'd2)) begin
        want.pred_taken = 1'b1;
        want.pred_next  = pc + imm_b;
    end else if (ret && (ras_m.size() != 0)) begin
        want.pred_taken = 1'b1;
        want.pred_next  = ras_m.pop_back();
    end
    if (link) begin
        ras_m.push_back(pc + 32'd4);
        // oldest entry falls out
        if (ras_m.size() > RAS_DEPTH) begin
            void'(ras_m.pop_front());
        end
    end
endtask

////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////

task automatic compare_pkt(input fetch_pkt_t got, input fetch_pkt_t want, input string what);
    chk_cnt++;
    if (got !== want) begin
        err_cnt++;
        $display("Error at %0t: %s got pc %h instr %h taken %b next %h",
                 $time, what, got.pc, got.instr, got.pred_taken, got.pred_next);
        $display("    expected pc %h instr %h taken %b next %h",
                 want.pc, want.instr, want.pred_taken, want.pred_next);
    end
endtask

task automatic compare_count(input int got, input int want, input string what);
    chk_cnt++;
    if (got != want) begin
        err_cnt++;
        $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, want);
    end
endtask

`endif

// ==== tests/fetch_unit_tb.sv ====
`default_nettype none

module fetch_unit_tb;

    import fetch_pkg::*;

    localparam int BHT_IDX_BITS = 6;
    localparam int RAS_DEPTH    = 4;
    localparam int CREDITS      = 4;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 10;
    localparam int RESET_CYCLES = 5;

    localparam int STREAM_LEN   = 300;
    localparam int HOLD_FILL    = 30;
    localparam int HOLD_QUIET   = 5;
    localparam int PROBE_WAIT   = 40;
    localparam int BACKEND_LEN  = 400;
    localparam int CALL_LEN     = 80;
    localparam int HOLD_LEN     = HOLD_FILL + HOLD_QUIET + PROBE_WAIT;
    localparam int TRAIN_LEN    = 2 * (6 + PROBE_WAIT);
    localparam int TOTAL_CYCLES = STREAM_LEN + HOLD_LEN + BACKEND_LEN + TRAIN_LEN + CALL_LEN;

    // image slots with fixed code
    localparam int          PROBE_SLOT = 160;
    localparam int          PROBE_OFF  = 32;
    localparam int          CALL_SLOT  = 192;
    localparam logic [31:0] PROBE_PC   = 32'(PROBE_SLOT * 4);
    localparam logic [31:0] CALL_PC    = 32'(CALL_SLOT * 4);
    localparam logic [31:0] RET_WORD   = 32'h0000_8067;
    localparam logic [31:0] JALR_X7    = 32'h0003_80e7;

    `include "fetch_tb_util.svh"

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic        imem_req_o;
    logic [31:0] imem_addr_o;
    logic [31:0] imem_rdata_i;
    logic        pkt_valid_o;
    fetch_pkt_t  pkt_o;
    logic        credit_i;
    redirect_t   redirect_i;
    bht_update_t bht_upd_i;

    logic [31:0] img [256];
    logic [31:0] exp_pc;
    int          outstanding;
    int          pkt_cnt;
    int          req_cnt;
    int          ret_empty_cnt;
    int          ret_pop_cnt;
    logic        credit_hold;
    redirect_t   nxt_redir;
    bht_update_t nxt_upd;
    bht_update_t pend_upd;
    logic        last_valid;
    fetch_pkt_t  last_pkt;

    fetch_unit #(
        .BHT_IDX_BITS(BHT_IDX_BITS),
        .RAS_DEPTH   (RAS_DEPTH),
        .CREDITS     (CREDITS)
    ) DUT (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .imem_req_o  (imem_req_o),
        .imem_addr_o (imem_addr_o),
        .imem_rdata_i(imem_rdata_i),
        .pkt_valid_o (pkt_valid_o),
        .pkt_o       (pkt_o),
        .credit_i    (credit_i),
        .redirect_i  (redirect_i),
        .bht_upd_i   (bht_upd_i)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // image repeats every 1 KB
    function automatic logic [31:0] img_word(input logic [31:0] addr);
        return img[addr[9:2]];
    endfunction

    function automatic logic [31:0] rand_pc();
        logic [31:0] r;
        r = rand_bits(8);
        return {22'd0, r[7:0], 2'b00};
    endfunction

    function automatic logic [31:0] branch_word(input int off);
        instr_u      w;
        logic [12:0] imm;
        logic [31:0] r;
        imm        = 13'(off);
        r          = rand_bits(11);
        w.raw      = '0;
        w.b.opcode = OPC_BRANCH;
        w.b.funct3 = {2'b00, r[10]};
        w.b.rs1    = r[9:5];
        w.b.rs2    = r[4:0];
        w.b.imm12  = imm[12];
        w.b.imm11  = imm[11];
        w.b.imm10_5 = imm[10:5];
        w.b.imm4_1 = imm[4:1];
        return w.raw;
    endfunction

    // call through x1
    function automatic logic [31:0] jal_word(input int off);
        instr_u      w;
        logic [20:0] imm;
        imm        = 21'(off);
        w.raw      = '0;
        w.j.opcode = OPC_JAL;
        w.j.rd     = 5'd1;
        w.j.imm20  = imm[20];
        w.j.imm10_1 = imm[10:1];
        w.j.imm11  = imm[11];
        {w.j.rs1, w.j.funct3} = imm[19:12];
        return w.raw;
    endfunction

    task automatic build_image();
        logic [3:0]  kind;
        logic [31:0] r;
        int          off;
        for (int i = 0; i < 256; i++) begin
            kind = 4'(rand_bits(4));
            off  = int'(rand_bits(4)) + 1;
            if (rand_bits(1) != 0) begin
                off = -off;
            end
            r = rand_bits(25);
            if (kind < 4'd9) begin
                img[i] = {r[24:0], 7'b0010011};
            end else if (kind < 4'd12) begin
                img[i] = branch_word(off * 4);
            end else if (kind < 4'd14) begin
                img[i] = jal_word(off * 4);
            end else if (kind == 4'd14) begin
                img[i] = RET_WORD;
            end else begin
                img[i] = JALR_X7;
            end
        end
        img[PROBE_SLOT] = branch_word(PROBE_OFF);
        // six nested calls with a return after each call site
        for (int k = 0; k < 6; k++) begin
            img[CALL_SLOT + 2 * k]     = jal_word(8);
            img[CALL_SLOT + 2 * k + 1] = RET_WORD;
        end
        img[CALL_SLOT + 12] = RET_WORD;
    endtask

    ////////////////////////////////////////////////////////////
    // check at the falling edge and drive after the rising one
    ////////////////////////////////////////////////////////////

    task automatic step_cycle();
        fetch_pkt_t  want;
        logic [31:0] word;
        logic        req;
        logic [31:0] addr;
        @(negedge clk);
        last_valid = pkt_valid_o;
        last_pkt   = pkt_o;
        if (pkt_valid_o) begin
            word = img_word(exp_pc);
            if ((word == RET_WORD) && (ras_m.size() == 0)) begin
                ret_empty_cnt++;
            end else if (word == RET_WORD) begin
                ret_pop_cnt++;
            end
            predict_packet(exp_pc, word, want);
            compare_pkt(pkt_o, want, "packet");
            exp_pc = want.pred_next;
            outstanding++;
            pkt_cnt++;
            if (outstanding > CREDITS) begin
                compare_count(outstanding, CREDITS, "outstanding packets");
            end
        end
        if (redirect_i.valid) begin
            exp_pc = redirect_i.pc;
        end
        // an update counts for lookups one cycle later
        train_counters(pend_upd);
        pend_upd = bht_upd_i;
        req  = imem_req_o;
        addr = imem_addr_o;
        if (req) begin
            req_cnt++;
        end
        @(posedge clk);
        #DRIVE_DLY;
        imem_rdata_i = req ? img_word(addr) : '0;
        redirect_i   = nxt_redir;
        bht_upd_i    = nxt_upd;
        nxt_redir    = '0;
        nxt_upd      = '0;
        credit_i     = 1'b0;
        if (!credit_hold && (outstanding > 0) && (rand_bits(2) != 0)) begin
            credit_i = 1'b1;
            outstanding--;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        $display("test %-10s done, %0d errors", name, err_cnt - err0);
    endtask

    task automatic stream_test();
        int err0;
        err0 = err_cnt;
        repeat (STREAM_LEN) step_cycle();
        report_test("sequential", err0);
    endtask

    task automatic credit_test();
        int err0;
        int n0;
        int q0;
        int waited;
        err0 = err_cnt;
        credit_hold = 1'b1;
        repeat (HOLD_FILL) step_cycle();
        compare_count(outstanding, CREDITS, "outstanding with credits held");
        n0 = pkt_cnt;
        q0 = req_cnt;
        repeat (HOLD_QUIET) step_cycle();
        compare_count(pkt_cnt - n0, 0, "packets without credit");
        compare_count(req_cnt - q0, 0, "requests without credit");
        credit_hold = 1'b0;
        waited = 0;
        while ((pkt_cnt == n0) && (waited < PROBE_WAIT)) begin
            step_cycle();
            waited++;
        end
        if (pkt_cnt == n0) begin
            $display("credits: no packet arrived after credits were returned");
            err_cnt++;
        end
        report_test("credits", err0);
    endtask

    task automatic redirect_test();
        int          err0;
        logic [31:0] r;
        err0 = err_cnt;
        for (int i = 0; i < BACKEND_LEN; i++) begin
            if (rand_bits(4) == 0) begin
                nxt_redir = '{valid: 1'b1, pc: rand_pc()};
            end
            if (rand_bits(2) == 0) begin
                r       = rand_bits(1);
                nxt_upd = '{valid: 1'b1, pc: rand_pc(), taken: r[0]};
            end
            step_cycle();
        end
        report_test("redirect", err0);
    endtask

    // three updates saturate far enough to set the direction
    task automatic probe_branch(input logic taken);
        fetch_pkt_t want;
        int         waited;
        for (int i = 0; i < 3; i++) begin
            nxt_upd = '{valid: 1'b1, pc: PROBE_PC, taken: taken};
            step_cycle();
        end
        nxt_redir = '{valid: 1'b1, pc: PROBE_PC};
        step_cycle();
        step_cycle();
        step_cycle();
        waited = 0;
        while (!last_valid && (waited < PROBE_WAIT)) begin
            step_cycle();
            waited++;
        end
        if (!last_valid) begin
            $display("training: no packet arrived after the redirect to the branch");
            err_cnt++;
        end else begin
            want.pc         = PROBE_PC;
            want.instr      = img_word(PROBE_PC);
            want.pred_taken = taken;
            want.pred_next  = taken ? PROBE_PC + 32'(PROBE_OFF) : PROBE_PC + 32'd4;
            compare_pkt(last_pkt, want, "trained branch");
        end
    endtask

    task automatic training_test();
        int err0;
        err0 = err_cnt;
        probe_branch(1'b1);
        probe_branch(1'b0);
        report_test("training", err0);
    endtask

    task automatic call_test();
        int err0;
        int e0;
        int p0;
        err0 = err_cnt;
        e0   = ret_empty_cnt;
        p0   = ret_pop_cnt;
        nxt_redir = '{valid: 1'b1, pc: CALL_PC};
        repeat (CALL_LEN) step_cycle();
        if (ret_pop_cnt - p0 < RAS_DEPTH) begin
            $display("calls: fewer returns came from the stack than its depth");
            err_cnt++;
        end
        if (ret_empty_cnt == e0) begin
            $display("calls: no return was fetched with the stack empty");
            err_cnt++;
        end
        report_test("calls", err0);
    endtask

    initial begin
        #(TOTAL_CYCLES * 4 * CLK_PERIOD);
        $display("timeout: the tests ran longer than their cycle budget");
        $display("Regression failed");
        $finish;
    end

    initial begin
        rst_n_i       = 1'b0;
        imem_rdata_i  = '0;
        credit_i      = 1'b0;
        redirect_i    = '0;
        bht_upd_i     = '0;
        nxt_redir     = '0;
        nxt_upd       = '0;
        pend_upd      = '0;
        credit_hold   = 1'b0;
        last_valid    = 1'b0;
        last_pkt      = '0;
        outstanding   = 0;
        pkt_cnt       = 0;
        req_cnt       = 0;
        ret_empty_cnt = 0;
        ret_pop_cnt   = 0;
        err_cnt       = 0;
        chk_cnt       = 0;
        lfsr_q        = 32'd69;
        exp_pc        = RESET_PC;
        clear_model();
        build_image();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n_i = 1'b1;
        stream_test();
        credit_test();
        redirect_test();
        training_test();
        call_test();
        $display("5 tests, %0d packets, %0d checks, %0d errors", pkt_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fetch_unit.f ====
+incdir+include
hdl/fetch_pkg.sv
hdl/pc_gen.sv
hdl/predecode.sv
hdl/branch_predictor.sv
hdl/return_stack.sv
hdl/fetch_stage.sv
hdl/fetch_unit.sv
tests/fetch_unit_tb.sv
